// ==== filelist.f ====
+incdir+logic
logic/trig_pkg.sv
logic/trig_capture.sv
logic/run_ctrl.sv
logic/trig_readout.sv
logic/trig_out_queue.sv
logic/trig_process_top.sv
sim/tb_trig_process.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the trigger processing testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_trig_process -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_trig_process)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
    exit 0
fi
exit 1

// ==== sim/tb_trig_process.sv ====
`include "trig_defs.svh"

module tb_trig_process;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = 24;
    localparam int OFFSET = 5;
    localparam int HOLDOFF = 6;
    // six tests, each bounded by the longest one with margin
    localparam int TEST_CYCLES = 200;
    localparam int TIMEOUT_CYCLES = 6 * TEST_CYCLES;

    logic                                  sysclk_i;
    logic                                  runrst_i;
    logic                                  run_start_i;
    logic                                  run_stop_i;
    trig_pkg::lat_cnt_t                    trig_latency_i;
    trig_pkg::trig_addr_t                  trig_offset_i;
    trig_pkg::lat_cnt_t                    trig_holdoff_i;
    trig_pkg::src_mask_t                   trigmask_i;
    logic                                  trigmask_update_i;
    logic [`TRIG_NSRC*`TRIG_WORD_BITS-1:0] trig_word_i;
    logic                                  running_o;
    trig_pkg::trig_addr_t                  address_o;
    logic                                  trig_req_o;
    trig_pkg::trig_addr_t                  trig_addr_o;
    trig_pkg::src_mask_t                   trig_src_o;
    logic                                  overflow_o;
    logic                                  trig_ack_i;

    integer seed = 34;
    int     errors;
    int     delivered;
    int     cycle_cnt;
    string  test_name;
    // consumer withholds ack while set
    bit     hold_ack;

    // reference model keeps one mark set per slot
    trig_pkg::src_mask_t  model_marks [1 << `TRIG_ADDR_BITS];
    trig_pkg::src_mask_t  model_mask;
    bit                   model_running;
    int                   model_holdoff;
    // write-side address the current test places its words against
    trig_pkg::trig_addr_t ref_addr;
    trig_pkg::trig_addr_t exp_addr_q [$];
    trig_pkg::src_mask_t  exp_src_q [$];
    bit                   head_valid;
    trig_pkg::trig_addr_t head_addr;
    trig_pkg::src_mask_t  head_src;
    logic [`TRIG_NSRC*`TRIG_WORD_BITS-1:0] word_buf;

    trig_process_top trig_process_top_inst (.*);

    always #20 sysclk_i = ~sysclk_i;

    // hang guard
    always @(posedge sysclk_i) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // every delivered report must match the oldest predicted one
    assert property (@(posedge sysclk_i) disable iff (runrst_i)
        $rose(trig_req_o) |-> (head_valid && trig_addr_o == head_addr
                               && trig_src_o == head_src))
    else begin
        errors++;
        if (!head_valid) begin
            $display("%s: report at addr %0h arrived with none expected",
                     test_name, $sampled(trig_addr_o));
        end else begin
            $display("error %s: expected addr %0h src %b, actual addr %0h src %b", test_name,
                     head_addr, head_src, $sampled(trig_addr_o), $sampled(trig_src_o));
        end
    end

    // req may only rise on an edge that saw ack low
    assert property (@(posedge sysclk_i) disable iff (runrst_i)
        $rose(trig_req_o) |-> !$past(trig_ack_i))
    else begin
        errors++;
        $display("%s: req rose while ack was still high", test_name);
    end

    // consumer side of the handshake
    // ack follows req after 0 to 3 cycles and lets go 0 to 2 cycles after req falls
    initial begin
        int delay;
        int drop_delay;
        trig_ack_i = 1'b0;
        delay = 0;
        drop_delay = 0;
        forever begin
            @(negedge sysclk_i);
            if (trig_req_o && !trig_ack_i && !hold_ack) begin
                if (delay == 0) begin
                    trig_ack_i = 1'b1;
                    delay = int'({$random(seed)} % 4);
                end else begin
                    delay--;
                end
            end else if (!trig_req_o && trig_ack_i) begin
                if (drop_delay == 0) begin
                    trig_ack_i = 1'b0;
                    drop_delay = int'({$random(seed)} % 3);
                    // entry retired on both sides
                    if (exp_addr_q.size() != 0) begin
                        void'(exp_addr_q.pop_front());
                        void'(exp_src_q.pop_front());
                    end
                    delivered++;
                    refresh_head();
                end else begin
                    drop_delay--;
                end
            end
        end
    end

    function automatic void refresh_head();
        head_valid = (exp_addr_q.size() != 0);
        if (head_valid) begin
            head_addr = exp_addr_q[0];
            head_src  = exp_src_q[0];
        end
    endfunction

    function automatic int rand_ahead(input int span);
        return 2 + int'({$random(seed)} % span);
    endfunction

    // one word k slots ahead
    // the model marks it only if capture is expected to take it
    function automatic void load_word(input int src, input int k, input bit valid);
        trig_pkg::trig_addr_t addr;
        logic [`TRIG_WORD_BITS-1:0] word;
        addr = ref_addr + trig_pkg::trig_addr_t'(k);
        word = `TRIG_WORD_BITS'($random(seed));
        word[`TRIG_VALID_BIT] = valid;
        word[`TRIG_ADDR_LSB +: `TRIG_ADDR_BITS] = addr;
        word_buf[src*`TRIG_WORD_BITS +: `TRIG_WORD_BITS] = word;
        if (valid && !model_mask[src] && model_running) begin
            model_marks[addr][src] = 1'b1;
        end
    endfunction

    // walk slots in read order
    // cap is the room left in the report queue
    function automatic void predict_reports(input int cap);
        trig_pkg::trig_addr_t a;
        trig_pkg::trig_addr_t last_a;
        bit fired;
        int kept;
        fired = 1'b0;
        kept = 0;
        last_a = '0;
        for (int k = 0; k < 32; k++) begin
            a = ref_addr + trig_pkg::trig_addr_t'(k);
            if (model_marks[a] != '0) begin
                // reads inside the holdoff window are cleared silently
                if (!fired || int'(trig_pkg::trig_addr_t'(a - last_a)) > model_holdoff) begin
                    fired = 1'b1;
                    last_a = a;
                    if (kept < cap) begin
                        exp_addr_q.push_back(a - trig_pkg::trig_addr_t'(OFFSET));
                        exp_src_q.push_back(model_marks[a]);
                        kept++;
                    end
                end
                model_marks[a] = '0;
            end
        end
        refresh_head();
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            errors++;
            $display("error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge sysclk_i);
    endtask

    task automatic send_words();
        trig_word_i = word_buf;
        @(negedge sysclk_i);
        trig_word_i = '0;
        word_buf = '0;
    endtask

    task automatic set_mask(input trig_pkg::src_mask_t m);
        trigmask_i = m;
        trigmask_update_i = 1'b1;
        model_mask = m;
        @(negedge sysclk_i);
        trigmask_update_i = 1'b0;
    endtask

    task automatic start_run(input int holdoff);
        trig_latency_i = trig_pkg::lat_cnt_t'(LATENCY);
        trig_offset_i = trig_pkg::trig_addr_t'(OFFSET);
        trig_holdoff_i = trig_pkg::lat_cnt_t'(holdoff);
        model_holdoff = holdoff;
        run_start_i = 1'b1;
        @(negedge sysclk_i);
        run_start_i = 1'b0;
        model_running = 1'b1;
    endtask

    task automatic stop_run();
        run_stop_i = 1'b1;
        @(negedge sysclk_i);
        run_stop_i = 1'b0;
        model_running = 1'b0;
    endtask

    // all predicted reports through and then room for strays to show up
    task automatic wait_drained();
        while (exp_addr_q.size() != 0 || trig_ack_i) begin
            @(negedge sysclk_i);
        end
        idle_cycles(LATENCY + 24);
    endtask

    initial begin
        int k;
        sysclk_i = 1'b0;
        runrst_i = 1'b1;
        run_start_i = 1'b0;
        run_stop_i = 1'b0;
        trig_latency_i = '0;
        trig_offset_i = '0;
        trig_holdoff_i = '0;
        trigmask_i = '1;
        trigmask_update_i = 1'b0;
        trig_word_i = '0;
        word_buf = '0;
        model_mask = '1;
        model_running = 1'b0;
        model_holdoff = 0;
        hold_ack = 1'b0;
        foreach (model_marks[i]) begin
            model_marks[i] = '0;
        end
        refresh_head();
        test_name = "reset";
        repeat (5) @(posedge sysclk_i);
        @(negedge sysclk_i);
        runrst_i = 1'b0;

        test_name = "reset_and_count";
        check_value("running_o", 0, running_o);
        check_value("trig_req_o", 0, trig_req_o);
        check_value("overflow_o", 0, overflow_o);
        check_value("address_o", 0, address_o);
        start_run(0);
        check_value("running_o", 1, running_o);
        for (int n = 1; n <= 8; n++) begin
            check_value("address_o", n, address_o);
            @(negedge sysclk_i);
        end

        // source 3 masked and source 1 sends a word without the valid flag
        test_name = "mask_and_valid";
        set_mask(4'b1000);
        ref_addr = address_o;
        k = rand_ahead(6);
        load_word(0, k, 1'b1);
        load_word(3, k + 4, 1'b1);
        load_word(1, k + 8, 1'b0);
        send_words();
        predict_reports(99);
        wait_drained();

        // later slot on a lower source plus two sources sharing one slot
        test_name = "merge_and_order";
        set_mask('0);
        ref_addr = address_o;
        k = rand_ahead(6);
        load_word(2, k + 9, 1'b1);
        load_word(0, k, 1'b1);
        load_word(3, k, 1'b1);
        load_word(1, k + 5, 1'b1);
        send_words();
        predict_reports(99);
        wait_drained();

        // six reports against a stalled consumer
        test_name = "overflow";
        hold_ack = 1'b1;
        ref_addr = address_o;
        k = rand_ahead(4);
        for (int s = 0; s < `TRIG_NSRC; s++) begin
            load_word(s, k + 2*s, 1'b1);
        end
        send_words();
        load_word(0, k + 8, 1'b1);
        load_word(1, k + 10, 1'b1);
        send_words();
        predict_reports(`TRIG_QUEUE_DEPTH);
        idle_cycles(LATENCY + 24);
        check_value("overflow_o", 1, overflow_o);
        hold_ack = 1'b0;
        wait_drained();

        // fresh run where the middle mark falls inside the holdoff window
        test_name = "holdoff";
        stop_run();
        start_run(HOLDOFF);
        ref_addr = address_o;
        k = rand_ahead(6);
        load_word(0, k, 1'b1);
        load_word(1, k + 3, 1'b1);
        load_word(2, k + HOLDOFF + 1, 1'b1);
        send_words();
        predict_reports(99);
        wait_drained();

        test_name = "stopped";
        stop_run();
        check_value("running_o", 0, running_o);
        check_value("address_o", 0, address_o);
        ref_addr = address_o;
        for (int s = 0; s < `TRIG_NSRC; s++) begin
            load_word(s, rand_ahead(18), 1'b1);
        end
        send_words();
        predict_reports(99);
        // restart so any slot marked while stopped would reach the readout
        start_run(0);
        idle_cycles(LATENCY);
        wait_drained();

        $display("summary: %0d reports delivered, %0d errors", delivered, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== logic/trig_process_top.sv ====
`include "trig_defs.svh"

module trig_process_top (
    input  logic                                  sysclk_i,
    input  logic                                  runrst_i,
    input  logic                                  run_start_i,
    input  logic                                  run_stop_i,
    input  trig_pkg::lat_cnt_t                    trig_latency_i,
    input  trig_pkg::trig_addr_t                  trig_offset_i,
    input  trig_pkg::lat_cnt_t                    trig_holdoff_i,
    input  trig_pkg::src_mask_t                   trigmask_i,
    input  logic                                  trigmask_update_i,
    input  logic [`TRIG_NSRC*`TRIG_WORD_BITS-1:0] trig_word_i,
    output logic                                  running_o,
    output trig_pkg::trig_addr_t                  address_o,
    output logic                                  trig_req_o,
    output trig_pkg::trig_addr_t                  trig_addr_o,
    output trig_pkg::src_mask_t                   trig_src_o,
    output logic                                  overflow_o,
    input  logic                                  trig_ack_i
);

    // run control to capture and readout
    logic                                  running;
    logic                                  rd_en;
    trig_pkg::trig_addr_t                  rd_addr;
    trig_pkg::trig_addr_t                  run_offset;
    trig_pkg::lat_cnt_t                    run_holdoff;
    // capture to mark memory
    trig_pkg::src_mask_t                   mark_we;
    logic [`TRIG_NSRC*`TRIG_ADDR_BITS-1:0] mark_addr;
    // readout to report queue
    logic                                  rep_valid;
    trig_pkg::trig_addr_t                  rep_addr;
    trig_pkg::src_mask_t                   rep_src;

    assign running_o = running;

    run_ctrl run_ctrl_inst (
        .sysclk_i       (sysclk_i),
        .runrst_i       (runrst_i),
        .run_start_i    (run_start_i),
        .run_stop_i     (run_stop_i),
        .trig_latency_i (trig_latency_i),
        .trig_offset_i  (trig_offset_i),
        .trig_holdoff_i (trig_holdoff_i),
        .running_o      (running),
        .address_o      (address_o),
        .rd_en_o        (rd_en),
        .rd_addr_o      (rd_addr),
        .run_offset_o   (run_offset),
        .run_holdoff_o  (run_holdoff)
    );

    trig_capture trig_capture_inst (
        .sysclk_i          (sysclk_i),
        .runrst_i          (runrst_i),
        .running_i         (running),
        .trigmask_i        (trigmask_i),
        .trigmask_update_i (trigmask_update_i),
        .trig_word_i       (trig_word_i),
        .mark_we_o         (mark_we),
        .mark_addr_o       (mark_addr)
    );

    trig_readout trig_readout_inst (
        .sysclk_i      (sysclk_i),
        .runrst_i      (runrst_i),
        .mark_we_i     (mark_we),
        .mark_addr_i   (mark_addr),
        .rd_en_i       (rd_en),
        .rd_addr_i     (rd_addr),
        .run_offset_i  (run_offset),
        .run_holdoff_i (run_holdoff),
        .rep_valid_o   (rep_valid),
        .rep_addr_o    (rep_addr),
        .rep_src_o     (rep_src)
    );

    trig_out_queue trig_out_queue_inst (
        .sysclk_i    (sysclk_i),
        .runrst_i    (runrst_i),
        .rep_valid_i (rep_valid),
        .rep_addr_i  (rep_addr),
        .rep_src_i   (rep_src),
        .trig_req_o  (trig_req_o),
        .trig_addr_o (trig_addr_o),
        .trig_src_o  (trig_src_o),
        .trig_ack_i  (trig_ack_i),
        .overflow_o  (overflow_o)
    );

endmodule

// ==== logic/trig_out_queue.sv ====
`include "trig_defs.svh"

module trig_out_queue (
    input  logic                 sysclk_i,
    input  logic                 runrst_i,
    input  logic                 rep_valid_i,
    input  trig_pkg::trig_addr_t rep_addr_i,
    input  trig_pkg::src_mask_t  rep_src_i,
    output logic                 trig_req_o,
    output trig_pkg::trig_addr_t trig_addr_o,
    output trig_pkg::src_mask_t  trig_src_o,
    input  logic                 trig_ack_i,
    output logic                 overflow_o
);

    // queue storage, address and source set per entry
    trig_pkg::trig_addr_t q_addr [`TRIG_QUEUE_DEPTH];
    trig_pkg::src_mask_t  q_src  [`TRIG_QUEUE_DEPTH];

    logic [`TRIG_QPTR_BITS-1:0] wr_ptr_q;
    logic [`TRIG_QPTR_BITS-1:0] rd_ptr_q;
    // entries held, one bit wider than the pointers
    logic [`TRIG_QPTR_BITS:0]   count_q;

    trig_pkg::hs_state_e hs_state_q;
    logic                full;
    logic                push;
    logic                pop;

    assign full = (count_q == (`TRIG_QPTR_BITS+1)'(`TRIG_QUEUE_DEPTH));
    // no back-pressure upstream, pushes into a full queue are lost
    assign push = rep_valid_i && !full;
    // entry retires once the consumer acknowledges it
    assign pop  = (hs_state_q == trig_pkg::HS_REQ) && trig_ack_i;

    // storage write
    always_ff @(posedge sysclk_i) begin
        if (push) begin
            q_addr[wr_ptr_q] <= rep_addr_i;
            q_src[wr_ptr_q]  <= rep_src_i;
        end
    end

    // pointers, fill count and sticky overflow
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
            if (rep_valid_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    // four-phase handshake
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            hs_state_q <= trig_pkg::HS_IDLE;
        end else begin
            case (hs_state_q)
                trig_pkg::HS_IDLE: begin
                    // req only rises with ack already low
                    if (count_q != '0 && !trig_ack_i) begin
                        hs_state_q <= trig_pkg::HS_REQ;
                    end
                end
                trig_pkg::HS_REQ: begin
                    if (trig_ack_i) begin
                        hs_state_q <= trig_pkg::HS_RELEASE;
                    end
                end
                trig_pkg::HS_RELEASE: begin
                    // wait for the consumer to let go of ack
                    if (!trig_ack_i) begin
                        hs_state_q <= trig_pkg::HS_IDLE;
                    end
                end
                default: begin
                    hs_state_q <= trig_pkg::HS_IDLE;
                end
            endcase
        end
    end

    assign trig_req_o  = (hs_state_q == trig_pkg::HS_REQ);
    // head entry holds still while req is up
    assign trig_addr_o = q_addr[rd_ptr_q];
    assign trig_src_o  = q_src[rd_ptr_q];

endmodule

// ==== logic/trig_readout.sv ====
`include "trig_defs.svh"

module trig_readout (
    input  logic                                  sysclk_i,
    input  logic                                  runrst_i,
    input  trig_pkg::src_mask_t                   mark_we_i,
    input  logic [`TRIG_NSRC*`TRIG_ADDR_BITS-1:0] mark_addr_i,
    input  logic                                  rd_en_i,
    input  trig_pkg::trig_addr_t                  rd_addr_i,
    input  trig_pkg::trig_addr_t                  run_offset_i,
    input  trig_pkg::lat_cnt_t                    run_holdoff_i,
    output logic                                  rep_valid_o,
    output trig_pkg::trig_addr_t                  rep_addr_o,
    output trig_pkg::src_mask_t                   rep_src_o
);

    localparam int NSLOT = 1 << `TRIG_ADDR_BITS;

    // one mark bit per source in every buffer slot
    trig_pkg::src_mask_t mark_mem [NSLOT];
    // slot contents under the readout pointer
    trig_pkg::src_mask_t rd_marks;
    // holdoff cycles still to run
    trig_pkg::lat_cnt_t  hold_cnt_q;
    logic                hold_active;
    logic                fire;

    assign rd_marks    = mark_mem[rd_addr_i];
    assign hold_active = (hold_cnt_q != '0);
    // a marked slot reports only outside the holdoff window
    assign fire        = rd_en_i && (|rd_marks) && !hold_active;

    // mark memory, read and clear at the pointer
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            for (int i = 0; i < NSLOT; i++) begin
                mark_mem[i] <= '0;
            end
        end else begin
            if (rd_en_i) begin
                mark_mem[rd_addr_i] <= '0;
            end
            // marks come after the clear so a same-slot write survives
            for (int s = 0; s < `TRIG_NSRC; s++) begin
                if (mark_we_i[s]) begin
                    mark_mem[mark_addr_i[s*`TRIG_ADDR_BITS +: `TRIG_ADDR_BITS]][s] <= 1'b1;
                end
            end
        end
    end

    // holdoff counter and report strobe
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            hold_cnt_q  <= '0;
            rep_valid_o <= 1'b0;
        end else begin
            rep_valid_o <= fire;
            if (fire) begin
                // blocks exactly run_holdoff following reads
                hold_cnt_q <= run_holdoff_i;
            end else if (hold_active) begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
            end
        end
    end

    // report payload, address shifted back by the run offset
    always_ff @(posedge sysclk_i) begin
        rep_addr_o <= rd_addr_i - run_offset_i;
        rep_src_o  <= rd_marks;
    end

endmodule

// ==== logic/run_ctrl.sv ====
`include "trig_defs.svh"

module run_ctrl (
    input  logic                 sysclk_i,
    input  logic                 runrst_i,
    input  logic                 run_start_i,
    input  logic                 run_stop_i,
    input  trig_pkg::lat_cnt_t   trig_latency_i,
    input  trig_pkg::trig_addr_t trig_offset_i,
    input  trig_pkg::lat_cnt_t   trig_holdoff_i,
    output logic                 running_o,
    output trig_pkg::trig_addr_t address_o,
    output logic                 rd_en_o,
    output trig_pkg::trig_addr_t rd_addr_o,
    output trig_pkg::trig_addr_t run_offset_o,
    output trig_pkg::lat_cnt_t   run_holdoff_o
);

    trig_pkg::run_state_e state_q;
    // latency captured at run start
    trig_pkg::lat_cnt_t   run_latency_q;
    // running cycles seen so far
    trig_pkg::lat_cnt_t   lat_cnt_q;
    trig_pkg::lat_cnt_t   lat_cnt_next;

    assign lat_cnt_next = lat_cnt_q + 1'b1;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            state_q       <= trig_pkg::RUN_IDLE;
            run_latency_q <= '0;
            run_offset_o  <= '0;
            run_holdoff_o <= '0;
            lat_cnt_q     <= '0;
            address_o     <= '0;
            rd_addr_o     <= '0;
        end else if (run_stop_i) begin
            // stop wins over anything else
            state_q   <= trig_pkg::RUN_IDLE;
            address_o <= '0;
        end else begin
            case (state_q)
                trig_pkg::RUN_IDLE: begin
                    if (run_start_i) begin
                        // run parameters frozen for the whole run
                        run_latency_q <= trig_latency_i;
                        run_offset_o  <= trig_offset_i;
                        run_holdoff_o <= trig_holdoff_i;
                        lat_cnt_q     <= '0;
                        rd_addr_o     <= '0;
                        // write side starts at 1 in the first running cycle
                        address_o     <= 8'd1;
                        // zero latency goes straight to readout
                        if (trig_latency_i == '0) begin
                            state_q <= trig_pkg::RUN_READOUT;
                        end else begin
                            state_q <= trig_pkg::RUN_LATENCY;
                        end
                    end
                end
                trig_pkg::RUN_LATENCY: begin
                    address_o <= address_o + 1'b1;
                    lat_cnt_q <= lat_cnt_next;
                    // readout begins once latency cycles have passed, so
                    // the pointer trails the write side by latency plus one
                    if (lat_cnt_next == run_latency_q) begin
                        state_q <= trig_pkg::RUN_READOUT;
                    end
                end
                trig_pkg::RUN_READOUT: begin
                    address_o <= address_o + 1'b1;
                    rd_addr_o <= rd_addr_o + 1'b1;
                end
                default: begin
                    state_q <= trig_pkg::RUN_IDLE;
                end
            endcase
        end
    end

    assign running_o = (state_q != trig_pkg::RUN_IDLE);
    assign rd_en_o   = (state_q == trig_pkg::RUN_READOUT);

endmodule

// ==== logic/trig_capture.sv ====
`include "trig_defs.svh"

module trig_capture (
    input  logic                                       sysclk_i,
    input  logic                                       runrst_i,
    input  logic                                       running_i,
    input  trig_pkg::src_mask_t                        trigmask_i,
    input  logic                                       trigmask_update_i,
    input  logic [`TRIG_NSRC*`TRIG_WORD_BITS-1:0]      trig_word_i,
    output trig_pkg::src_mask_t                        mark_we_o,
    output logic [`TRIG_NSRC*`TRIG_ADDR_BITS-1:0]      mark_addr_o
);

    // active mask, a set bit blocks that source
    trig_pkg::src_mask_t mask_q;
    // combinational hit per source
    trig_pkg::src_mask_t hit;

    // a hit needs the valid flag, an open mask and a running block
    always_comb begin
        for (int s = 0; s < `TRIG_NSRC; s++) begin
            hit[s] = trig_word_i[s*`TRIG_WORD_BITS + `TRIG_VALID_BIT]
                     && !mask_q[s] && running_i;
        end
    end

    // mask register and registered write enables
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            // everything masked out of reset
            mask_q    <= '1;
            mark_we_o <= '0;
        end else begin
            if (trigmask_update_i) begin
                mask_q <= trigmask_i;
            end
            // write strobe lands one edge after the word was sampled
            mark_we_o <= hit;
        end
    end

    // address field rides along with the strobe
    always_ff @(posedge sysclk_i) begin
        for (int s = 0; s < `TRIG_NSRC; s++) begin
            // bits below the address field carry nothing useful
            mark_addr_o[s*`TRIG_ADDR_BITS +: `TRIG_ADDR_BITS] <=
                trig_word_i[s*`TRIG_WORD_BITS + `TRIG_ADDR_LSB +: `TRIG_ADDR_BITS];
        end
    end

endmodule

// ==== logic/trig_pkg.sv ====
`include "trig_defs.svh"

package trig_pkg;

    // buffer address, wraps at the memory size
    typedef logic [`TRIG_ADDR_BITS-1:0] trig_addr_t;

    // one bit per trigger source
    typedef logic [`TRIG_NSRC-1:0] src_mask_t;

    // latency and holdoff counts
    typedef logic [`TRIG_LAT_BITS-1:0] lat_cnt_t;

    // run control states
    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_LATENCY,
        RUN_READOUT
    } run_state_e;

    // four-phase output handshake states
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_RELEASE
    } hs_state_e;

endpackage

// ==== logic/trig_defs.svh ====
`ifndef TRIG_DEFS_SVH
`define TRIG_DEFS_SVH

// number of trigger sources feeding the block
`define TRIG_NSRC 4

// one trigger word per source
`define TRIG_WORD_BITS 16

// bit 15 flags a valid word
`define TRIG_VALID_BIT 15

// buffer address field sits above the two unused low bits
`define TRIG_ADDR_LSB 2
`define TRIG_ADDR_BITS 8

// latency and holdoff values
`define TRIG_LAT_BITS 16

// report queue, depth must be a power of two
`define TRIG_QUEUE_DEPTH 4
`define TRIG_QPTR_BITS 2

`endif
